//--- rtl/executeStage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage with forwarding muxes and ALU
// owns the memory stage register
// wbWrType must be cleared when writeback is empty
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module executeStage
    import isaPkg::*, pipePkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic                advance,
    input  logic                exeValid,
    input  exePayloadT          exePayload,
    input  logic [regAddrW-1:0] wbDst,
    input  regsWrT              wbWrType,
    input  logic [dataW-1:0]    wbResult,
    output logic                memValid,
    output memPayloadT          memPayload
);

    fwdSelT           fwdA;
    fwdSelT           fwdB;
    regsWrT           memWrType;
    logic [dataW-1:0] opA;
    logic [dataW-1:0] opB;
    logic [dataW-1:0] immExt;
    logic [dataW-1:0] aluOut;
    memPayloadT       exeOut;

    assign memWrType = memValid ? memPayload.wrType : '0;   // bubble writes nothing

    forwardUnit fwd (
        .exeRs     (exePayload.rs),
        .exeRt     (exePayload.rt),
        .exeRd     (exePayload.rd),
        .exeReadSel(exePayload.readSel),
        .memDst    (memPayload.dst),
        .memWrType (memWrType),
        .wbDst     (wbDst),
        .wbWrType  (wbWrType),
        .fwdA      (fwdA),
        .fwdB      (fwdB)
    );

    always_comb begin
        unique case (fwdA)
            fwdMemAlu:  opA = memPayload.aluOut;
            fwdWbRes:   opA = wbResult;
            default:    opA = exePayload.opA;
        endcase
    end

    always_comb begin
        unique case (fwdB)
            fwdMemAlu:  opB = memPayload.aluOut;
            fwdWbRes:   opB = wbResult;
            fwdMemOutB: opB = memPayload.outB;
            default:    opB = exePayload.opB;
        endcase
    end

    assign immExt = {{(dataW - immW){exePayload.imm[immW-1]}}, exePayload.imm};

    always_comb begin
        unique case (exePayload.op)
            opAdd:   aluOut = opA + opB;
            opSub:   aluOut = opA - opB;
            opAnd:   aluOut = opA & opB;
            opOr:    aluOut = opA | opB;
            opXor:   aluOut = opA ^ opB;
            opAddi:  aluOut = opA + immExt;
            default: aluOut = opB;   // MFC0 and MTC0 move operand B
        endcase
    end

    assign exeOut.wrType = exePayload.wrType;
    assign exeOut.dst    = exePayload.dst;
    assign exeOut.aluOut = aluOut;
    assign exeOut.outB   = opB;

    stageReg #(.payloadT(memPayloadT)) memReg (
        .clk       (clk),
        .arstN     (arstN),
        .advance   (advance),
        .inValid   (exeValid),
        .inPayload (exeOut),
        .outValid  (memValid),
        .outPayload(memPayload)
    );

    // a stalled execute keeps forwarding from the same writeback entry
    assert property (@(posedge clk) disable iff (!arstN)
        !advance |=> $stable(wbDst) && $stable(wbWrType) && $stable(wbResult))
        else $error("writeback source moved under a stalled execute");

endmodule

//--- rtl/forwardCore.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top of the three-stage execute slice
// wbReady low stalls every stage and the input
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module forwardCore
    import isaPkg::*, pipePkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic                inValid,
    input  opT                  inOp,
    input  logic [regAddrW-1:0] inRs,
    input  logic [regAddrW-1:0] inRt,
    input  logic [regAddrW-1:0] inRd,
    input  logic [immW-1:0]     inImm,
    input  logic                wbReady,
    output logic                inReady,
    output logic                wbValid,
    output logic [regAddrW-1:0] wbDst,
    output logic [dataW-1:0]    wbData,
    output logic                wbCp0
);

    logic                advance;
    logic                wbFire;
    logic [regAddrW-1:0] rdAddrA;
    logic [regAddrW-1:0] rdAddrB;
    logic                rdCp0;
    logic [dataW-1:0]    rdDataA;
    logic [dataW-1:0]    rdDataB;
    logic                exeValid;
    exePayloadT          exePayload;
    logic                memValid;
    memPayloadT          memPayload;
    wbPayloadT           wbIn;
    wbPayloadT           wbPayload;
    regsWrT              wbWrType;

    assign advance = !wbValid || wbReady;   // empty writeback never blocks
    assign wbFire  = wbValid && wbReady;

    issueStage issue (
        .clk       (clk),
        .arstN     (arstN),
        .inValid   (inValid),
        .inOp      (inOp),
        .inRs      (inRs),
        .inRt      (inRt),
        .inRd      (inRd),
        .inImm     (inImm),
        .advance   (advance),
        .inReady   (inReady),
        .rdAddrA   (rdAddrA),
        .rdAddrB   (rdAddrB),
        .rdCp0     (rdCp0),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .exeValid  (exeValid),
        .exePayload(exePayload)
    );

    executeStage execute (
        .clk       (clk),
        .arstN     (arstN),
        .advance   (advance),
        .exeValid  (exeValid),
        .exePayload(exePayload),
        .wbDst     (wbPayload.dst),
        .wbWrType  (wbWrType),
        .wbResult  (wbPayload.result),
        .memValid  (memValid),
        .memPayload(memPayload)
    );

    // memory stage is a plain register, pick the retiring value here
    assign wbIn.wrType = memPayload.wrType;
    assign wbIn.dst    = memPayload.dst;
    assign wbIn.result = memPayload.wrType.cp0Wr ? memPayload.outB : memPayload.aluOut;

    stageReg #(.payloadT(wbPayloadT)) wbReg (
        .clk       (clk),
        .arstN     (arstN),
        .advance   (advance),
        .inValid   (memValid),
        .inPayload (wbIn),
        .outValid  (wbValid),
        .outPayload(wbPayload)
    );

    assign wbWrType = wbValid ? wbPayload.wrType : '0;
    assign wbDst    = wbPayload.dst;
    assign wbData   = wbPayload.result;
    assign wbCp0    = wbPayload.wrType.cp0Wr;

    // banks update on the writeback transfer edge
    regFile regs (
        .clk    (clk),
        .arstN  (arstN),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdCp0  (rdCp0),
        .wrEn   (wbFire && wbPayload.wrType.rfWr),
        .wrCp0  (wbFire && wbPayload.wrType.cp0Wr),
        .wrAddr (wbPayload.dst),
        .wrData (wbPayload.result),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB)
    );

endmodule

//--- rtl/forwardUnit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand source selection for execute
// wrType inputs must already be cleared for bubbles
// the memory stage wins over writeback
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module forwardUnit
    import isaPkg::*, pipePkg::*;
(
    input  logic [regAddrW-1:0] exeRs,
    input  logic [regAddrW-1:0] exeRt,
    input  logic [regAddrW-1:0] exeRd,
    input  readSelT             exeReadSel,
    input  logic [regAddrW-1:0] memDst,
    input  regsWrT              memWrType,
    input  logic [regAddrW-1:0] wbDst,
    input  regsWrT              wbWrType,
    output fwdSelT              fwdA,
    output fwdSelT              fwdB
);

    // register-file hits, r0 never forwards
    logic memHitRs;
    logic wbHitRs;
    logic memHitRt;
    logic wbHitRt;
    // cp0 hits on rd
    logic memHitCp0;
    logic wbHitCp0;

    assign memHitRs  = memWrType.rfWr && memDst != '0 && memDst == exeRs;
    assign wbHitRs   = wbWrType.rfWr && wbDst != '0 && wbDst == exeRs;
    assign memHitRt  = memWrType.rfWr && memDst != '0 && memDst == exeRt;
    assign wbHitRt   = wbWrType.rfWr && wbDst != '0 && wbDst == exeRt;
    assign memHitCp0 = memWrType.cp0Wr && memDst == exeRd;
    assign wbHitCp0  = wbWrType.cp0Wr && wbDst == exeRd;

    always_comb begin
        if (memHitRs)
            fwdA = fwdMemAlu;
        else if (wbHitRs)
            fwdA = fwdWbRes;
        else
            fwdA = fwdRegs;
    end

    always_comb begin
        fwdB = fwdRegs;   // immediate operand never forwards
        unique case (exeReadSel)
            selRf: begin
                if (memHitRt)
                    fwdB = fwdMemAlu;
                else if (wbHitRt)
                    fwdB = fwdWbRes;
            end
            selCp0: begin
                if (memHitCp0)
                    fwdB = fwdMemOutB;   // MTC0 data still in outB
                else if (wbHitCp0)
                    fwdB = fwdWbRes;
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/isaPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction set of the execute slice
// only register ALU ops, ADDI and the CP0 moves
// no loads, stores, branches or HI/LO
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isaPkg;

    // datapath and field widths
    localparam int dataW    = 32;
    localparam int regAddrW = 5;
    localparam int immW     = 16;              // raw immediate, sign-extended in execute
    localparam int regNum   = 1 << regAddrW;   // entries per register bank

    // decoded operation, one per instruction
    typedef enum logic [2:0] {
        opAdd  = 3'd0,
        opSub  = 3'd1,
        opAnd  = 3'd2,
        opOr   = 3'd3,
        opXor  = 3'd4,
        opAddi = 3'd5,   // rt = rs + sext(imm)
        opMtc0 = 3'd6,   // cp0[rd] = rt
        opMfc0 = 3'd7    // rt = cp0[rd]
    } opT;

endpackage

//--- rtl/issueStage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage, accepts one instruction per cycle
// the sender must hold the instruction while
// inValid is high and inReady is low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module issueStage
    import isaPkg::*, pipePkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic                inValid,
    input  opT                  inOp,
    input  logic [regAddrW-1:0] inRs,
    input  logic [regAddrW-1:0] inRt,
    input  logic [regAddrW-1:0] inRd,
    input  logic [immW-1:0]     inImm,
    input  logic                advance,
    output logic                inReady,
    output logic [regAddrW-1:0] rdAddrA,
    output logic [regAddrW-1:0] rdAddrB,
    output logic                rdCp0,
    input  logic [dataW-1:0]    rdDataA,
    input  logic [dataW-1:0]    rdDataB,
    output logic                exeValid,
    output exePayloadT          exePayload
);

    regsWrT              wrType;
    readSelT             readSel;
    logic [regAddrW-1:0] dst;
    exePayloadT          issuePayload;

    assign inReady = advance;

    // decode
    always_comb begin
        wrType  = '0;
        readSel = selRf;
        dst     = inRd;
        unique case (inOp)
            opAdd, opSub, opAnd, opOr, opXor: begin
                wrType.rfWr = 1'b1;
            end
            opAddi: begin
                wrType.rfWr = 1'b1;
                readSel     = selImm;
                dst         = inRt;
            end
            opMtc0: begin
                wrType.cp0Wr = 1'b1;   // data comes from rt
            end
            opMfc0: begin
                wrType.rfWr = 1'b1;
                readSel     = selCp0;
                dst         = inRt;
            end
            default: ;
        endcase
    end

    // port B reads cp0[rd] for MFC0, rt otherwise
    assign rdAddrA = inRs;
    assign rdAddrB = (readSel == selCp0) ? inRd : inRt;
    assign rdCp0   = (readSel == selCp0);

    always_comb begin
        issuePayload.op      = inOp;
        issuePayload.rs      = inRs;
        issuePayload.rt      = inRt;
        issuePayload.rd      = inRd;
        issuePayload.wrType  = wrType;
        issuePayload.readSel = readSel;
        issuePayload.dst     = dst;
        issuePayload.opA     = rdDataA;
        issuePayload.opB     = rdDataB;
        issuePayload.imm     = inImm;
    end

    stageReg #(.payloadT(exePayloadT)) exeReg (
        .clk       (clk),
        .arstN     (arstN),
        .advance   (advance),
        .inValid   (inValid),
        .inPayload (issuePayload),
        .outValid  (exeValid),
        .outPayload(exePayload)
    );

    // stalled offers must not change under the pipe
    assert property (@(posedge clk) disable iff (!arstN)
        inValid && !inReady |=> inValid && $stable({inOp, inRs, inRt, inRd, inImm}))
        else $error("input changed while stalled");

endmodule

//--- rtl/pipePkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipeline types shared by issue, execute and top
// payload structs are packed, stageReg relies on it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package pipePkg;
    import isaPkg::*;

    // which bank an instruction writes
    typedef struct packed {
        logic rfWr;
        logic cp0Wr;
    } regsWrT;

    // operand B source picked at issue
    typedef enum logic [1:0] {
        selRf  = 2'b00,
        selImm = 2'b01,
        selCp0 = 2'b11
    } readSelT;

    // operand source in execute
    typedef enum logic [1:0] {
        fwdRegs    = 2'b00,   // value read at issue
        fwdMemAlu  = 2'b01,
        fwdWbRes   = 2'b10,
        fwdMemOutB = 2'b11    // pending MTC0 data
    } fwdSelT;

    typedef struct packed {
        opT                  op;
        logic [regAddrW-1:0] rs;
        logic [regAddrW-1:0] rt;
        logic [regAddrW-1:0] rd;
        regsWrT              wrType;
        readSelT             readSel;
        logic [regAddrW-1:0] dst;
        logic [dataW-1:0]    opA;
        logic [dataW-1:0]    opB;
        logic [immW-1:0]     imm;
    } exePayloadT;

    typedef struct packed {
        regsWrT              wrType;
        logic [regAddrW-1:0] dst;
        logic [dataW-1:0]    aluOut;
        logic [dataW-1:0]    outB;
    } memPayloadT;

    typedef struct packed {
        regsWrT              wrType;
        logic [regAddrW-1:0] dst;
        logic [dataW-1:0]    result;
    } wbPayloadT;

endpackage

//--- rtl/regFile.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// general and CP0 register banks, both reset to 0
// port B reads CP0 when rdCp0 is high
// a same-cycle write bypasses to the matching read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module regFile
    import isaPkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic [regAddrW-1:0] rdAddrA,
    input  logic [regAddrW-1:0] rdAddrB,
    input  logic                rdCp0,
    input  logic                wrEn,     // general bank write
    input  logic                wrCp0,    // cp0 bank write
    input  logic [regAddrW-1:0] wrAddr,
    input  logic [dataW-1:0]    wrData,
    output logic [dataW-1:0]    rdDataA,
    output logic [dataW-1:0]    rdDataB
);

    logic [dataW-1:0] gpr [regNum];
    logic [dataW-1:0] cp0 [regNum];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regNum; i++) begin
                gpr[i] <= '0;
                cp0[i] <= '0;
            end
        end else begin
            if (wrEn && wrAddr != '0)   // r0 stays zero
                gpr[wrAddr] <= wrData;
            if (wrCp0)
                cp0[wrAddr] <= wrData;
        end
    end

    always_comb begin
        if (rdAddrA == '0)
            rdDataA = '0;
        else if (wrEn && wrAddr == rdAddrA)
            rdDataA = wrData;   // distance-three bypass
        else
            rdDataA = gpr[rdAddrA];
    end

    always_comb begin
        if (rdCp0)
            rdDataB = (wrCp0 && wrAddr == rdAddrB) ? wrData : cp0[rdAddrB];
        else if (rdAddrB == '0)
            rdDataB = '0;
        else if (wrEn && wrAddr == rdAddrB)
            rdDataB = wrData;
        else
            rdDataB = gpr[rdAddrB];
    end

endmodule

//--- rtl/stageReg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one pipeline stage register with a valid bit
// payloadT must be a packed type
// payload is not reset and only means something with outValid
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    advance,    // low holds the stage
    input  logic    inValid,
    input  payloadT inPayload,
    output logic    outValid,
    output payloadT outPayload
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            outValid <= 1'b0;
        else if (advance)
            outValid <= inValid;   // bubbles pass through as well
    end

    always_ff @(posedge clk) begin
        if (advance)
            outPayload <= inPayload;
    end

    // an offer stalled at this stage stays valid until it moves
    assert property (@(posedge clk) disable iff (!arstN)
        !advance && inValid |=> inValid)
        else $error("offer withdrawn during stall");

endmodule

//--- run.sh
#!/bin/sh
# build and run the forwarding testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module tbForward -o simTb

./obj_dir/simTb > sim.log 2>&1 || true
cat sim.log

# the log decides the result
if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation finished cleanly"

//--- tests/tbRefModel.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// architectural model of the general and CP0 banks
// included in the testbench module body, needs isaPkg
// one expected retirement is queued per accepted op
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

logic [dataW-1:0]    refGpr [regNum];
logic [dataW-1:0]    refCp0 [regNum];
logic [regAddrW-1:0] expDst [$];    // expected retirements, program order
logic [dataW-1:0]    expData [$];
logic                expCp0 [$];

function automatic void refReset();
    for (int i = 0; i < regNum; i++) begin
        refGpr[i] = '0;
        refCp0[i] = '0;
    end
    expDst.delete();
    expData.delete();
    expCp0.delete();
endfunction

// executes one instruction in program order
function automatic void refStep(input opT op, input logic [regAddrW-1:0] rs,
                                input logic [regAddrW-1:0] rt,
                                input logic [regAddrW-1:0] rd,
                                input logic [immW-1:0] imm);
    logic [dataW-1:0]    a;
    logic [dataW-1:0]    b;
    logic [dataW-1:0]    res;
    logic [regAddrW-1:0] dst;
    a   = refGpr[rs];
    b   = refGpr[rt];
    dst = rd;   // register ops and MTC0
    case (op)
        opAdd:  res = a + b;
        opSub:  res = a - b;
        opAnd:  res = a & b;
        opOr:   res = a | b;
        opXor:  res = a ^ b;
        opAddi: begin
            res = a + {{(dataW - immW){imm[immW-1]}}, imm};
            dst = rt;
        end
        opMtc0: res = b;
        opMfc0: begin
            res = refCp0[rd];
            dst = rt;
        end
    endcase
    if (op == opMtc0)
        refCp0[rd] = res;
    else if (dst != '0)
        refGpr[dst] = res;   // r0 write still retires on the port
    expDst.push_back(dst);
    expData.push_back(res);
    expCp0.push_back(op == opMtc0);
endfunction

//--- tests/tbForward.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the forwarding execute slice
// directed hazards first with wbReady high,
// then random ops on r0..r3 under back-pressure
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tbForward
    import isaPkg::*;
();

    localparam int waitLimit = 64;    // cycles allowed per wait
    localparam int randCount = 400;   // random instructions

    logic                clk;
    logic                arstN;
    logic                inValid;
    opT                  inOp;
    logic [regAddrW-1:0] inRs;
    logic [regAddrW-1:0] inRt;
    logic [regAddrW-1:0] inRd;
    logic [immW-1:0]     inImm;
    logic                wbReady;
    logic                inReady;
    logic                wbValid;
    logic [regAddrW-1:0] wbDst;
    logic [dataW-1:0]    wbData;
    logic                wbCp0;

    logic [31:0] lfsr;
    logic        randReady;   // random wbReady when set
    logic        resetSeen;
    int          valueErrs = 0;
    int          orderErrs = 0;
    int          hsErrs = 0;

    `include "tbRefModel.svh"

    forwardCore dut0 (
        .clk    (clk),
        .arstN  (arstN),
        .inValid(inValid),
        .inOp   (inOp),
        .inRs   (inRs),
        .inRt   (inRt),
        .inRd   (inRd),
        .inImm  (inImm),
        .wbReady(wbReady),
        .inReady(inReady),
        .wbValid(wbValid),
        .wbDst  (wbDst),
        .wbData (wbData),
        .wbCp0  (wbCp0)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic checkData(input logic [dataW-1:0] got, input logic [dataW-1:0] exp);
        if (got !== exp) begin
            valueErrs++;
            $display("ERR %0t: wbData got %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic checkDst(input logic [regAddrW-1:0] got, input logic [regAddrW-1:0] exp);
        if (got !== exp) begin
            valueErrs++;
            $display("ERR %0t: wbDst got %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic checkCp0(input logic got, input logic exp);
        if (got !== exp) begin
            valueErrs++;
            $display("ERR %0t: wbCp0 got %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s at %0t", why, $time);
        $display("errors: value %0d, order %0d, handshake %0d", valueErrs, orderErrs, hsErrs);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // one clock, then pick wbReady for the next cycle
    task automatic tick();
        logic [31:0] bits;
        @(posedge clk);
        if (randReady) begin
            bits = randBits(2);
            wbReady <= (bits[1:0] != 2'b00);   // ready 3 of 4 cycles
        end else begin
            wbReady <= 1'b1;
        end
    endtask

    task automatic issue(input opT op, input logic [regAddrW-1:0] rs,
                         input logic [regAddrW-1:0] rt, input logic [regAddrW-1:0] rd,
                         input logic [immW-1:0] imm);
        int cycles;
        inValid <= 1'b1;
        inOp    <= op;
        inRs    <= rs;
        inRt    <= rt;
        inRd    <= rd;
        inImm   <= imm;
        cycles  = 0;
        tick();
        while (!inReady) begin   // held until the transfer edge
            cycles++;
            if (cycles > waitLimit)
                abortRun("inReady stuck low, instruction never accepted");
            tick();
        end
        inValid <= 1'b0;
    endtask

    // model steps on input transfers, queue pops on writeback transfers
    always @(posedge clk) begin
        if (!arstN) begin
            refReset();
            resetSeen = 1'b1;
        end else begin
            if (resetSeen && (wbValid || !inReady)) begin
                hsErrs++;
                $display("wbValid high or inReady low after reset at %0t", $time);
            end
            resetSeen = 1'b0;
            if (wbValid && wbReady) begin
                if (expDst.size() == 0) begin
                    orderErrs++;
                    $display("writeback at %0t with no write pending", $time);
                end else begin
                    checkDst(wbDst, expDst.pop_front());
                    checkData(wbData, expData.pop_front());
                    checkCp0(wbCp0, expCp0.pop_front());
                end
            end
            if (wbValid && !wbReady && inReady) begin
                hsErrs++;
                $display("inReady high while writeback is stalled at %0t", $time);
            end
            if (inValid && inReady)
                refStep(inOp, inRs, inRt, inRd, inImm);
        end
    end

    initial begin
        logic [31:0]         rBits;
        opT                  rOp;
        logic [regAddrW-1:0] rRs;
        logic [regAddrW-1:0] rRt;
        logic [regAddrW-1:0] rRd;
        logic [immW-1:0]     rImm;
        int                  cycles;
        arstN     = 1'b0;
        inValid   = 1'b0;
        inOp      = opAdd;
        inRs      = '0;
        inRt      = '0;
        inRd      = '0;
        inImm     = '0;
        wbReady   = 1'b1;
        randReady = 1'b0;
        lfsr      = 32'hf97df7a6;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        tick();

        issue(opAddi, 5'd0, 5'd1, 5'd0, 16'h0007);   // r1 = 7
        issue(opAddi, 5'd1, 5'd2, 5'd0, 16'hfffd);   // mem forward, negative imm
        issue(opAdd, 5'd1, 5'd2, 5'd3, 16'h0000);    // r1 at distance two
        issue(opSub, 5'd3, 5'd1, 5'd1, 16'h0000);    // r1 at distance three
        issue(opXor, 5'd1, 5'd3, 5'd2, 16'h0000);
        issue(opAddi, 5'd2, 5'd0, 5'd0, 16'h0055);   // r0 write retires
        issue(opAdd, 5'd0, 5'd2, 5'd1, 16'h0000);    // r0 not forwarded
        issue(opOr, 5'd0, 5'd3, 5'd2, 16'h0000);
        issue(opAnd, 5'd3, 5'd0, 5'd3, 16'h0000);
        issue(opAddi, 5'd0, 5'd3, 5'd0, 16'h1234);
        issue(opMtc0, 5'd0, 5'd3, 5'd2, 16'h0000);   // cp0[2] = r3
        issue(opMfc0, 5'd0, 5'd1, 5'd2, 16'h0000);   // distance one
        issue(opMtc0, 5'd0, 5'd1, 5'd3, 16'h0000);
        issue(opAddi, 5'd1, 5'd0, 5'd0, 16'h0001);
        issue(opMfc0, 5'd0, 5'd2, 5'd3, 16'h0000);   // distance two
        issue(opMtc0, 5'd0, 5'd2, 5'd1, 16'h0000);
        issue(opAddi, 5'd2, 5'd0, 5'd0, 16'h0002);
        issue(opAddi, 5'd2, 5'd0, 5'd0, 16'h0003);
        issue(opMfc0, 5'd0, 5'd3, 5'd1, 16'h0000);   // distance three

        randReady = 1'b1;
        for (int n = 0; n < randCount; n++) begin
            rBits = randBits(3);
            rOp   = opT'(rBits[2:0]);
            rBits = randBits(2);
            rRs   = {3'b000, rBits[1:0]};
            rBits = randBits(2);
            rRt   = {3'b000, rBits[1:0]};
            rBits = randBits(2);
            rRd   = {3'b000, rBits[1:0]};
            rBits = randBits(16);
            rImm  = rBits[15:0];
            issue(rOp, rRs, rRt, rRd, rImm);
            rBits = randBits(2);
            if (rBits[1:0] == 2'b00)
                tick();   // idle cycle
        end

        randReady = 1'b0;
        tick();
        @(negedge clk);
        cycles = 0;
        while (expDst.size() != 0 || wbValid) begin
            cycles++;
            if (cycles > waitLimit)
                abortRun("pipeline did not drain, writes were lost");
            @(negedge clk);
        end

        $display("errors: value %0d, order %0d, handshake %0d", valueErrs, orderErrs, hsErrs);
        if (valueErrs + orderErrs + hsErrs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tests
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/stageReg.sv
rtl/regFile.sv
rtl/forwardUnit.sv
rtl/issueStage.sv
rtl/executeStage.sv
rtl/forwardCore.sv
tests/tbForward.sv
